// File: dv/cpu_tb.sv
module cpu_tb;
  import cpu_pkg::*;

  localparam int SEED         = 93508;
  localparam int RESET_CYCLES = 16;
  localparam int ACK_LIMIT    = 8;   // cycles allowed for each ack edge
  localparam int LOOP_SEARCH  = 40;

  logic       clk;
  logic       rst_n;
  logic       load_req;
  imem_addr_t load_addr;
  word_t      load_data;
  logic       load_ack;
  word_t      pc;
  logic       retire_valid;
  reg_addr_t  retire_addr;
  word_t      retire_data;

  // program image and reference model
  word_t     prog [$];
  word_t     m_reg [REG_COUNT];
  word_t     m_dmem [DMEM_DEPTH];
  logic      m_z;
  int        dead_left;      // slots still to be skipped by a taken branch
  word_t     loop_pc;
  reg_addr_t exp_addr [$];
  word_t     exp_data [$];
  int        exp_idx = 0;    // next expected write

  int   retire_errs  = 0;
  int   proto_errs   = 0;
  int   misc_errs    = 0;
  int   retire_count = 0;
  int   run_limit    = 0;
  bit   run_started  = 1'b0;
  logic req_q        = 1'b0;
  logic rst_q        = 1'b1;

  cpu dut (
      .clk            ( clk )
    , .rst_n_i        ( rst_n )
    , .load_req_i     ( load_req )
    , .load_addr_i    ( load_addr )
    , .load_data_i    ( load_data )
    , .load_ack_o     ( load_ack )
    , .pc_o           ( pc )
    , .retire_valid_o ( retire_valid )
    , .retire_addr_o  ( retire_addr )
    , .retire_data_o  ( retire_data )
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ****************************************
  // instruction encoding
  // ****************************************
  function automatic word_t enc_dp(input logic [3:0] cond, input logic imm,
                                   input logic [3:0] opc, input int rn, input int rd,
                                   input int op2);
    logic s;
    s = (opc == OPC_CMP);  // compare sets flags
    return {cond, CLS_DP, imm, opc, s, 4'(rn), 4'(rd), 12'(op2)};
  endfunction

  // pre-indexed, offset added, word access, no base write-back
  function automatic word_t enc_ls(input logic load, input int rn, input int rd,
                                   input int off);
    return {COND_AL, CLS_LS, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, load, 4'(rn), 4'(rd), 12'(off)};
  endfunction

  function automatic word_t enc_br(input logic [3:0] cond, input int off);
    return {cond, 3'b101, 1'b0, 24'(off)};
  endfunction

  function automatic word_t alu_rule(input logic [3:0] opc, input word_t a, input word_t b);
    case (opc)
      OPC_ADD:          return a + b;
      OPC_SUB, OPC_CMP: return a - b;
      OPC_AND:          return a & b;
      OPC_ORR:          return a | b;
      default:          return b;  // mov
    endcase
  endfunction

  function automatic logic cond_pass(input logic [3:0] cond);
    case (cond)
      COND_EQ: return m_z;
      COND_NE: return !m_z;
      default: return 1'b1;
    endcase
  endfunction

  function automatic int error_total();
    return retire_errs + proto_errs + misc_errs;
  endfunction

  // ****************************************
  // program assembly with expected writes
  // ****************************************
  task automatic emit(input word_t w, output bit live);
    live = (dead_left == 0);
    if (!live) begin
      dead_left--;
    end
    prog.push_back(w);
  endtask

  task automatic expect_write(input int rd, input word_t v);
    m_reg[rd] = v;
    exp_addr.push_back(reg_addr_t'(rd));
    exp_data.push_back(v);
  endtask

  task automatic dp_result(input logic [3:0] opc, input int rd, input word_t res);
    if (opc == OPC_CMP) begin
      m_z = (res == '0);
    end else begin
      expect_write(rd, res);
    end
  endtask

  task automatic dp_imm(input logic [3:0] opc, input int rd, input int rn, input int imm);
    bit    live;
    word_t res;
    emit(enc_dp(COND_AL, 1'b1, opc, rn, rd, imm & 'hff), live);
    res = alu_rule(opc, m_reg[rn], word_t'(imm & 'hff));
    if (live) begin
      dp_result(opc, rd, res);
    end
  endtask

  task automatic dp_reg(input logic [3:0] opc, input int rd, input int rn, input int rm);
    bit    live;
    word_t res;
    emit(enc_dp(COND_AL, 1'b0, opc, rn, rd, rm), live);
    res = alu_rule(opc, m_reg[rn], m_reg[rm]);
    if (live) begin
      dp_result(opc, rd, res);
    end
  endtask

  task automatic mem_op(input logic load, input int rd, input int rn, input int off);
    bit    live;
    word_t addr;
    emit(enc_ls(load, rn, rd, off), live);
    addr = m_reg[rn] + word_t'(off);  // byte address
    if (live && load) begin
      expect_write(rd, m_dmem[addr[WIDX_HI:WIDX_LO]]);
    end else if (live) begin
      m_dmem[addr[WIDX_HI:WIDX_LO]] = m_reg[rd];
    end
  endtask

  // target is pc + 8 + 4 * off, so a forward branch skips off + 1 slots
  task automatic branch(input logic [3:0] cond, input int off);
    bit live;
    emit(enc_br(cond, off), live);
    if (live && cond_pass(cond)) begin
      if (off >= 0) begin
        dead_left = off + 1;
      end else begin
        dead_left = 1000;  // backward only for the final loop
      end
    end
  endtask

  task automatic build_program();
    int imm [7];
    foreach (imm[k]) imm[k] = $urandom_range(255, 0);
    foreach (m_reg[k]) m_reg[k] = '0;
    dead_left = 0;
    m_z       = 1'b0;
    // alu operations with random immediates
    dp_imm(OPC_MOV, 1, 0, imm[0]);
    dp_imm(OPC_MOV, 2, 0, imm[1]);
    dp_imm(OPC_ADD, 3, 1, imm[2]);
    dp_imm(OPC_SUB, 4, 2, imm[3]);
    dp_reg(OPC_AND, 5, 1, 2);
    dp_imm(OPC_ORR, 6, 1, imm[4]);
    dp_imm(OPC_MOV, 7, 0, imm[5]);
    dp_imm(OPC_AND, 8, 7, imm[6]);
    dp_reg(OPC_ORR, 9, 3, 4);
    dp_reg(OPC_SUB, 10, 1, 2);      // may wrap below zero
    // back-to-back dependences
    dp_imm(OPC_ADD, 11, 1, 1);
    dp_imm(OPC_ADD, 11, 11, 2);
    dp_reg(OPC_ADD, 11, 11, 11);
    dp_reg(OPC_ADD, 12, 11, 2);
    dp_imm(OPC_SUB, 12, 12, 3);
    // stores and loads at two addresses
    dp_imm(OPC_MOV, 0, 0, 'h40);
    mem_op(1'b0, 3, 0, 'h00);
    mem_op(1'b0, 12, 0, 'h14);
    mem_op(1'b1, 13, 0, 'h00);
    mem_op(1'b1, 14, 0, 'h14);
    dp_reg(OPC_ADD, 15, 13, 14);    // r15 is a plain register
    mem_op(1'b0, 9, 0, 'h08);
    mem_op(1'b1, 1, 0, 'h08);       // load right behind the store
    // branches
    dp_imm(OPC_MOV, 2, 0, 'h5a);
    dp_imm(OPC_CMP, 0, 2, 'h5a);
    branch(COND_EQ, 1);             // taken
    dp_imm(OPC_MOV, 3, 0, 'h11);
    dp_imm(OPC_MOV, 4, 0, 'h22);
    branch(COND_NE, 1);             // not taken
    dp_imm(OPC_MOV, 5, 0, 'h33);
    dp_imm(OPC_ADD, 6, 5, 1);
    dp_imm(OPC_CMP, 0, 6, 0);
    branch(COND_NE, 0);             // taken, skips one
    dp_imm(OPC_MOV, 7, 0, 'h77);
    dp_imm(OPC_MOV, 8, 0, 'h88);
    loop_pc = word_t'(prog.size() * 4);
    branch(COND_AL, -2);            // self loop
    dp_imm(OPC_MOV, 9, 0, 'hee);
    dp_imm(OPC_MOV, 10, 0, 'hdd);
  endtask

  // ****************************************
  // load port, four-phase handshake
  // ****************************************
  task automatic load_word(input int idx, input word_t w);
    int gap;
    int n;
    load_addr = imem_addr_t'(idx);
    load_data = w;
    gap = $urandom_range(3, 0);
    repeat (gap) @(negedge clk);
    load_req = 1'b1;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!load_ack && n < ACK_LIMIT);
    assert (load_ack) else begin
      misc_errs++;
      $display("no ack for instruction word %0d", idx);
    end
    gap = $urandom_range(3, 0);
    repeat (gap) @(negedge clk);
    load_req = 1'b0;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (load_ack && n < ACK_LIMIT);
    assert (!load_ack) else begin
      misc_errs++;
      $display("ack stayed high after req dropped for word %0d", idx);
    end
  endtask

  task automatic report_counts();
    $display("errors: %0d (retire %0d, handshake %0d, other %0d), %0d writes retired",
             error_total(), retire_errs, proto_errs, misc_errs, retire_count);
  endtask

  // ****************************************
  // checkers
  // ****************************************
  // in reset ack follows req one cycle later, both edges
  always @(posedge clk) begin
    if (!rst_q) begin
      assert (load_ack == req_q) else begin
        proto_errs++;
        $display("** Error load_ack_o: got %h expected %h", load_ack, req_q);
      end
      if (!rst_n) begin
        assert (!retire_valid) else begin
          proto_errs++;
          $display("** Error retire_valid_o: got %h expected %h", retire_valid, 1'b0);
        end
      end
    end
    req_q <= load_req;
    rst_q <= rst_n;
  end

  // retire scoreboard, in program order
  always @(posedge clk) begin
    if (rst_n && retire_valid) begin
      retire_count++;
      assert (exp_idx < exp_addr.size()) else begin
        retire_errs++;
        $display("unexpected write r%0d = %h after the last expected one",
                 retire_addr, retire_data);
      end
      if (exp_idx < exp_addr.size()) begin
        assert (retire_addr == exp_addr[exp_idx]) else begin
          retire_errs++;
          $display("** Error retire_addr_o: got %h expected %h", retire_addr, exp_addr[exp_idx]);
        end
        assert (retire_data == exp_data[exp_idx]) else begin
          retire_errs++;
          $display("** Error retire_data_o: got %h expected %h", retire_data, exp_data[exp_idx]);
        end
        exp_idx++;
      end
    end
  end

  initial begin : watchdog
    wait (run_started);
    repeat (run_limit) @(posedge clk);
    $display("watchdog: program did not finish within %0d cycles after reset", run_limit);
    report_counts();
    $display("Something failed");
    $finish;
  end

  // ****************************************
  // main sequence
  // ****************************************
  initial begin : main_seq
    int n;
    rst_n     = 1'b0;
    load_req  = 1'b0;
    load_addr = '0;
    load_data = '0;
    void'($urandom(SEED));
    build_program();
    // core held in reset, then kept there while the program loads
    repeat (RESET_CYCLES) @(negedge clk);
    foreach (prog[k]) load_word(k, prog[k]);
    run_limit = prog.size() * 10 + 200;
    @(negedge clk);
    rst_n       = 1'b1;
    run_started = 1'b1;

    while (exp_idx < exp_addr.size()) @(negedge clk);

    // loop alternates between its own pc and the squashed slot behind it
    n = 0;
    while (pc !== loop_pc && n < LOOP_SEARCH) begin
      @(negedge clk);
      n++;
    end
    assert (pc === loop_pc) else begin
      misc_errs++;
      $display("pc_o never reached the final loop at %h", loop_pc);
    end
    repeat (12) begin
      @(negedge clk);
      assert (pc == loop_pc || pc == loop_pc + PC_STEP) else begin
        misc_errs++;
        $display("** Error pc_o: got %h expected %h", pc, loop_pc);
      end
    end

    report_counts();
    if (error_total() == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: run.sh
#!/bin/sh
# build the cpu testbench with verilator, run it, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f verilog.f --top-module cpu_tb -o cpu_sim \
  && ./obj_dir/cpu_sim > sim.log 2>&1 \
  || echo "build or simulation did not complete"
grep -q "^Everything OK$" sim.log && echo "PASS" && exit 0 || { echo "FAIL"; exit 1; }

// File: src/cpu.sv
module cpu (
  input  logic                clk,
  input  logic                rst_n_i,
  input  logic                load_req_i,
  input  cpu_pkg::imem_addr_t load_addr_i,
  input  cpu_pkg::word_t      load_data_i,
  output logic                load_ack_o,
  output cpu_pkg::word_t      pc_o,
  output logic                retire_valid_o,
  output cpu_pkg::reg_addr_t  retire_addr_o,
  output cpu_pkg::word_t      retire_data_o
);
  import cpu_pkg::*;

  // fetch -> decode
  logic      valid_f_d;
  word_t     inst_f_d;
  word_t     pc_f_d;
  logic      stall_d_f;

  // decode -> execute
  logic      valid_d_e;
  word_t     r1_d_e;
  word_t     r2_d_e;
  reg_addr_t rd_d_e;
  word_t     inst_d_e;
  word_t     pc_d_e;

  // branch redirect, also the flush
  logic      branch;
  word_t     branch_addr;

  // execute -> mem
  logic      valid_e_m;
  word_t     alu_e_m;
  word_t     store_e_m;
  reg_addr_t rd_e_m;
  logic      reg_wr_e_m;
  logic      load_e_m;
  logic      store_en_e_m;

  // interlock info
  logic      ex_wr;
  reg_addr_t ex_rd;
  logic      mem_wr;
  reg_addr_t mem_rd;

  // write-back
  logic      wb_en;
  reg_addr_t wb_addr;
  word_t     wb_data;

  fetch fetch_module (
      .clk           ( clk )
    , .rst_n_i       ( rst_n_i )
    , .stall_i       ( stall_d_f )
    , .branch_i      ( branch )
    , .branch_addr_i ( branch_addr )
    , .load_req_i    ( load_req_i )
    , .load_addr_i   ( load_addr_i )
    , .load_data_i   ( load_data_i )
    , .load_ack_o    ( load_ack_o )
    , .valid_o       ( valid_f_d )
    , .inst_o        ( inst_f_d )
    , .pc_o          ( pc_f_d )
  );

  decode_reg_r decode_module (
      .clk       ( clk )
    , .rst_n_i   ( rst_n_i )
    , .valid_i   ( valid_f_d )
    , .inst_i    ( inst_f_d )
    , .pc_i      ( pc_f_d )
    , .flush_i   ( branch )
    , .ex_wr_i   ( ex_wr )
    , .ex_rd_i   ( ex_rd )
    , .mem_wr_i  ( mem_wr )
    , .mem_rd_i  ( mem_rd )
    , .wb_en_i   ( wb_en )
    , .wb_addr_i ( wb_addr )
    , .wb_data_i ( wb_data )
    , .stall_o   ( stall_d_f )
    , .valid_o   ( valid_d_e )
    , .r1_o      ( r1_d_e )
    , .r2_o      ( r2_d_e )
    , .rd_addr_o ( rd_d_e )
    , .inst_o    ( inst_d_e )
    , .pc_o      ( pc_d_e )
  );

  execute execute_module (
      .clk           ( clk )
    , .rst_n_i       ( rst_n_i )
    , .valid_i       ( valid_d_e )
    , .r1_i          ( r1_d_e )
    , .r2_i          ( r2_d_e )
    , .rd_addr_i     ( rd_d_e )
    , .inst_i        ( inst_d_e )
    , .pc_i          ( pc_d_e )
    , .branch_o      ( branch )
    , .branch_addr_o ( branch_addr )
    , .valid_o       ( valid_e_m )
    , .alu_data_o    ( alu_e_m )
    , .store_data_o  ( store_e_m )
    , .rd_addr_o     ( rd_e_m )
    , .reg_wr_o      ( reg_wr_e_m )
    , .is_load_o     ( load_e_m )
    , .is_store_o    ( store_en_e_m )
    , .wr_pending_o  ( ex_wr )
    , .wr_rd_o       ( ex_rd )
  );

  mem memory_module (
      .clk          ( clk )
    , .rst_n_i      ( rst_n_i )
    , .valid_i      ( valid_e_m )
    , .alu_data_i   ( alu_e_m )
    , .store_data_i ( store_e_m )
    , .rd_addr_i    ( rd_e_m )
    , .reg_wr_i     ( reg_wr_e_m )
    , .is_load_i    ( load_e_m )
    , .is_store_i   ( store_en_e_m )
    , .wr_pending_o ( mem_wr )
    , .wr_rd_o      ( mem_rd )
    , .wb_en_o      ( wb_en )
    , .wb_addr_o    ( wb_addr )
    , .wb_data_o    ( wb_data )
  );

  // retire port mirrors the register file write
  assign retire_valid_o = wb_en;
  assign retire_addr_o  = wb_addr;
  assign retire_data_o  = wb_data;

  assign pc_o = pc_f_d;  // pc of the instruction in decode

endmodule

// File: src/cpu_pkg.sv
package cpu_pkg;

  // ****************************************
  // widths
  // ****************************************
  typedef logic [31:0] word_t;       // data, instructions, byte addresses
  typedef logic [3:0]  reg_addr_t;   // r0..r15, r15 is a plain register here
  typedef logic [5:0]  imem_addr_t;  // instruction word index
  typedef logic [5:0]  dmem_addr_t;  // data word index

  localparam int IMEM_DEPTH = 64;
  localparam int DMEM_DEPTH = 64;
  localparam int REG_COUNT  = 16;

  // byte address -> word index
  localparam int WIDX_HI = 7;
  localparam int WIDX_LO = 2;

  localparam word_t PC_STEP  = 32'd4;
  localparam word_t PC_AHEAD = 32'd8;  // branch base is its own address plus 8

  // ****************************************
  // instruction fields
  // ****************************************
  localparam int COND_HI  = 31;
  localparam int COND_LO  = 28;
  localparam int CLS_HI   = 27;
  localparam int CLS_LO   = 26;
  localparam int I_BIT    = 25;  // operand 2 is the 8-bit immediate
  localparam int OPC_HI   = 24;
  localparam int OPC_LO   = 21;
  localparam int L_BIT    = 20;  // load when set
  localparam int RN_HI    = 19;
  localparam int RN_LO    = 16;
  localparam int RD_HI    = 15;
  localparam int RD_LO    = 12;
  localparam int RM_HI    = 3;
  localparam int RM_LO    = 0;
  localparam int IMM8_HI  = 7;
  localparam int OFF12_HI = 11;
  localparam int BOFF_HI  = 23;

  // instruction classes, bits 27:26
  localparam logic [1:0] CLS_DP = 2'b00;
  localparam logic [1:0] CLS_LS = 2'b01;
  localparam logic [1:0] CLS_BR = 2'b10;

  // data processing opcodes, ARM numbering
  localparam logic [3:0] OPC_AND = 4'd0;
  localparam logic [3:0] OPC_SUB = 4'd2;
  localparam logic [3:0] OPC_ADD = 4'd4;
  localparam logic [3:0] OPC_CMP = 4'd10;
  localparam logic [3:0] OPC_ORR = 4'd12;
  localparam logic [3:0] OPC_MOV = 4'd13;

  // conditions
  localparam logic [3:0] COND_EQ = 4'd0;
  localparam logic [3:0] COND_NE = 4'd1;
  localparam logic [3:0] COND_AL = 4'd14;

  // instruction memory loader
  typedef enum logic [1:0] {
    LD_IDLE,
    LD_WRITE,      // word written, ack up
    LD_WAIT_DROP   // waiting for req to fall
  } load_state_e;

endpackage

// File: src/decode_reg_r.sv
module decode_reg_r (
  input  logic               clk,
  input  logic               rst_n_i,
  input  logic               valid_i,
  input  cpu_pkg::word_t     inst_i,
  input  cpu_pkg::word_t     pc_i,
  input  logic               flush_i,
  input  logic               ex_wr_i,
  input  cpu_pkg::reg_addr_t ex_rd_i,
  input  logic               mem_wr_i,
  input  cpu_pkg::reg_addr_t mem_rd_i,
  input  logic               wb_en_i,
  input  cpu_pkg::reg_addr_t wb_addr_i,
  input  cpu_pkg::word_t     wb_data_i,
  output logic               stall_o,
  output logic               valid_o,
  output cpu_pkg::word_t     r1_o,
  output cpu_pkg::word_t     r2_o,
  output cpu_pkg::reg_addr_t rd_addr_o,
  output cpu_pkg::word_t     inst_o,
  output cpu_pkg::word_t     pc_o
);
  import cpu_pkg::*;

  word_t      rf [REG_COUNT];
  logic [1:0] cls;
  logic [3:0] opc;
  logic       is_store;
  reg_addr_t  rn;
  reg_addr_t  rd;
  reg_addr_t  ra2;      // second read port, rm or store source
  logic       use_rn;
  logic       use_r2;
  word_t      rn_val;
  word_t      r2_val;

  // register still in flight in execute or mem
  function automatic logic in_flight(input reg_addr_t a);
    in_flight = (ex_wr_i && ex_rd_i == a) || (mem_wr_i && mem_rd_i == a);
  endfunction

  // write in the same cycle is visible to the read
  function automatic word_t rf_read(input reg_addr_t a);
    rf_read = (wb_en_i && wb_addr_i == a) ? wb_data_i : rf[a];
  endfunction

  // ****************************************
  // decode
  // ****************************************
  assign cls      = inst_i[CLS_HI:CLS_LO];
  assign opc      = inst_i[OPC_HI:OPC_LO];
  assign is_store = (cls == CLS_LS) && !inst_i[L_BIT];
  assign rn       = inst_i[RN_HI:RN_LO];
  assign rd       = inst_i[RD_HI:RD_LO];
  assign ra2      = is_store ? rd : inst_i[RM_HI:RM_LO];

  // mov ignores rn, immediates and branches need no rm
  assign use_rn = valid_i && (((cls == CLS_DP) && opc != OPC_MOV) || cls == CLS_LS);
  assign use_r2 = valid_i && (((cls == CLS_DP) && !inst_i[I_BIT]) || is_store);

  assign stall_o = (use_rn && in_flight(rn)) || (use_r2 && in_flight(ra2));

  assign rn_val = rf_read(rn);
  assign r2_val = rf_read(ra2);

  // register file
  always_ff @(posedge clk) begin
    if (wb_en_i) begin
      rf[wb_addr_i] <= wb_data_i;
    end
  end

  // ****************************************
  // decode -> execute register
  // ****************************************
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i && !stall_o && !flush_i;  // bubble on stall or flush
    end
  end

  always_ff @(posedge clk) begin
    r1_o      <= rn_val;
    r2_o      <= r2_val;
    rd_addr_o <= rd;
    inst_o    <= inst_i;
    pc_o      <= pc_i;
  end

endmodule

// File: src/execute.sv
module execute (
  input  logic               clk,
  input  logic               rst_n_i,
  input  logic               valid_i,
  input  cpu_pkg::word_t     r1_i,
  input  cpu_pkg::word_t     r2_i,
  input  cpu_pkg::reg_addr_t rd_addr_i,
  input  cpu_pkg::word_t     inst_i,
  input  cpu_pkg::word_t     pc_i,
  output logic               branch_o,
  output cpu_pkg::word_t     branch_addr_o,
  output logic               valid_o,
  output cpu_pkg::word_t     alu_data_o,
  output cpu_pkg::word_t     store_data_o,
  output cpu_pkg::reg_addr_t rd_addr_o,
  output logic               reg_wr_o,
  output logic               is_load_o,
  output logic               is_store_o,
  output logic               wr_pending_o,
  output cpu_pkg::reg_addr_t wr_rd_o
);
  import cpu_pkg::*;

  logic [1:0] nz_q;       // {n, z}
  logic [1:0] cls;
  logic [3:0] opc;
  logic       is_dp;
  logic       is_ls;
  logic       is_br;
  logic       is_load;
  logic       writes_rd;
  logic       cond_ok;
  logic       exec;       // valid and condition passed
  word_t      op2;
  word_t      alu_res;
  word_t      mem_addr;

  assign cls   = inst_i[CLS_HI:CLS_LO];
  assign opc   = inst_i[OPC_HI:OPC_LO];
  assign is_dp = (cls == CLS_DP);
  assign is_ls = (cls == CLS_LS);
  assign is_br = (cls == CLS_BR);

  assign is_load   = is_ls && inst_i[L_BIT];
  assign writes_rd = (is_dp && opc != OPC_CMP) || is_load;

  // decode only needs to know the write is coming
  assign wr_pending_o = valid_i && writes_rd;
  assign wr_rd_o      = rd_addr_i;

  // ****************************************
  // condition check
  // ****************************************
  always_comb begin
    case (inst_i[COND_HI:COND_LO])
      COND_EQ: cond_ok = nz_q[0];
      COND_NE: cond_ok = !nz_q[0];
      COND_AL: cond_ok = 1'b1;
      default: cond_ok = 1'b0;  // unsupported, never executes
    endcase
  end

  assign exec = valid_i && cond_ok;

  // ****************************************
  // alu and address
  // ****************************************
  assign op2 = inst_i[I_BIT] ? word_t'(inst_i[IMM8_HI:0]) : r2_i;

  always_comb begin
    case (opc)
      OPC_AND:          alu_res = r1_i & op2;
      OPC_SUB, OPC_CMP: alu_res = r1_i - op2;
      OPC_ADD:          alu_res = r1_i + op2;
      OPC_ORR:          alu_res = r1_i | op2;
      OPC_MOV:          alu_res = op2;
      default:          alu_res = '0;
    endcase
  end

  assign mem_addr = r1_i + word_t'(inst_i[OFF12_HI:0]);  // byte address

  // branch resolves here, flushes fetch and decode
  assign branch_o      = exec && is_br;
  assign branch_addr_o = pc_i + PC_AHEAD
                       + {{6{inst_i[BOFF_HI]}}, inst_i[BOFF_HI:0], 2'b00};

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      nz_q <= 2'b00;
    end else if (exec && is_dp && opc == OPC_CMP) begin
      nz_q <= {alu_res[31], alu_res == '0};
    end
  end

  // ****************************************
  // execute -> mem register
  // ****************************************
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      valid_o    <= 1'b0;
      reg_wr_o   <= 1'b0;
      is_load_o  <= 1'b0;
      is_store_o <= 1'b0;
    end else begin
      valid_o    <= exec && !is_br;  // failed condition becomes a bubble
      reg_wr_o   <= exec && writes_rd;
      is_load_o  <= exec && is_load;
      is_store_o <= exec && is_ls && !inst_i[L_BIT];
    end
  end

  always_ff @(posedge clk) begin
    alu_data_o   <= is_ls ? mem_addr : alu_res;
    store_data_o <= r2_i;
    rd_addr_o    <= rd_addr_i;
  end

endmodule

// File: src/fetch.sv
module fetch (
  input  logic                clk,
  input  logic                rst_n_i,
  input  logic                stall_i,
  input  logic                branch_i,
  input  cpu_pkg::word_t      branch_addr_i,
  input  logic                load_req_i,
  input  cpu_pkg::imem_addr_t load_addr_i,
  input  cpu_pkg::word_t      load_data_i,
  output logic                load_ack_o,
  output logic                valid_o,
  output cpu_pkg::word_t      inst_o,
  output cpu_pkg::word_t      pc_o
);
  import cpu_pkg::*;

  word_t       imem [IMEM_DEPTH];
  word_t       pc_q;        // next fetch address in bytes
  imem_addr_t  fetch_idx;
  load_state_e ld_state;

  assign fetch_idx  = pc_q[WIDX_HI:WIDX_LO];
  assign load_ack_o = (ld_state != LD_IDLE);

  // ****************************************
  // program load, only while in reset
  // ****************************************
  always_ff @(posedge clk) begin
    if (rst_n_i) begin
      ld_state <= LD_IDLE;  // core running, loader parked
    end else begin
      case (ld_state)
        LD_IDLE: begin
          if (load_req_i) begin
            ld_state <= LD_WRITE;
          end
        end
        LD_WRITE: begin
          ld_state <= load_req_i ? LD_WAIT_DROP : LD_IDLE;
        end
        LD_WAIT_DROP: begin
          if (!load_req_i) begin
            ld_state <= LD_IDLE;  // ack drops one cycle after req
          end
        end
        default: ld_state <= LD_IDLE;
      endcase
    end
  end

  // word is taken on the req edge, ack follows
  always_ff @(posedge clk) begin
    if (!rst_n_i && ld_state == LD_IDLE && load_req_i) begin
      imem[load_addr_i] <= load_data_i;
    end
  end

  // ****************************************
  // pc and fetch register
  // ****************************************
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      pc_q    <= '0;
      valid_o <= 1'b0;
    end else if (branch_i) begin
      pc_q    <= branch_addr_i;
      valid_o <= 1'b0;  // squash the slot behind the branch
    end else if (!stall_i) begin
      inst_o  <= imem[fetch_idx];
      pc_o    <= pc_q;
      valid_o <= 1'b1;
      pc_q    <= pc_q + PC_STEP;
    end
  end

endmodule

// File: src/mem.sv
module mem (
  input  logic               clk,
  input  logic               rst_n_i,
  input  logic               valid_i,
  input  cpu_pkg::word_t     alu_data_i,
  input  cpu_pkg::word_t     store_data_i,
  input  cpu_pkg::reg_addr_t rd_addr_i,
  input  logic               reg_wr_i,
  input  logic               is_load_i,
  input  logic               is_store_i,
  output logic               wr_pending_o,
  output cpu_pkg::reg_addr_t wr_rd_o,
  output logic               wb_en_o,
  output cpu_pkg::reg_addr_t wb_addr_o,
  output cpu_pkg::word_t     wb_data_o
);
  import cpu_pkg::*;

  word_t      dmem [DMEM_DEPTH];
  dmem_addr_t d_idx;
  word_t      ld_word;

  assign d_idx   = alu_data_i[WIDX_HI:WIDX_LO];
  assign ld_word = dmem[d_idx];

  // still ahead of write-back, decode has to wait
  assign wr_pending_o = valid_i && reg_wr_i;
  assign wr_rd_o      = rd_addr_i;

  // ****************************************
  // data memory
  // ****************************************
  always_ff @(posedge clk) begin
    if (valid_i && is_store_i) begin
      dmem[d_idx] <= store_data_i;
    end
  end

  // ****************************************
  // write-back register
  // ****************************************
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      wb_en_o <= 1'b0;
    end else begin
      wb_en_o <= valid_i && reg_wr_i;
    end
  end

  always_ff @(posedge clk) begin
    wb_addr_o <= rd_addr_i;
    wb_data_o <= is_load_i ? ld_word : alu_data_i;  // load result or alu
  end

endmodule

// File: verilog.f
src/cpu_pkg.sv
src/fetch.sv
src/decode_reg_r.sv
src/execute.sv
src/mem.sv
src/cpu.sv
dv/cpu_tb.sv
